//--- all.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/i2c_cmd_queue.sv
hdl/i2c_master.sv
hdl/i2c_bus_arbiter.sv
hdl/i2c_reg_slave.sv
hdl/i2c_subsystem.sv
test/i2c_subsystem_props.sv
test/i2c_subsystem_tb.sv

//--- Bender.yml
package:
  name: i2c_subsystem

export_include_dirs:
  - hdl

sources:
  - hdl/i2c_pkg.sv
  - hdl/i2c_cmd_queue.sv
  - hdl/i2c_master.sv
  - hdl/i2c_bus_arbiter.sv
  - hdl/i2c_reg_slave.sv
  - hdl/i2c_subsystem.sv
  - target: test
    files:
      - test/i2c_subsystem_props.sv
      - test/i2c_subsystem_tb.sv

//--- test/i2c_subsystem_tb.sv
`include "i2c_cfg.svh"

module i2c_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import i2c_pkg::*;

  localparam int N     = `I2C_NUM_MASTERS;
  localparam int DEPTH = `I2C_QUEUE_DEPTH;

  typedef struct {
    string     name;
    int        port;
    logic      rw;
    i2c_addr_t addr;
    i2c_byte_t data;
    bit        wait_rsp;
  } step_t;

  logic         clk;
  logic         reset;
  logic [N-1:0] cmd_valid;
  i2c_cmd_t     cmd [N];
  logic [N-1:0] cmd_credit;
  logic [N-1:0] rsp_valid;
  i2c_rsp_t     rsp [N];
  i2c_line_t    bus;

  step_t     steps [$];
  string     pend_name [N][$];
  i2c_rsp_t  pend_rsp [N][$];
  int        credits [N];
  int        issued [N];
  int        returned [N];
  i2c_byte_t model_byte;
  int        stalls;
  int        checks;
  int        errors;
  int        other_errors;
  int        cycle_count;
  integer    seed;

  i2c_subsystem DUT (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .bus        (bus)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  function automatic void add_step(string name, int port, logic rw, i2c_addr_t addr,
                                   i2c_byte_t data, bit wait_rsp);
    step_t s;
    s.name     = name;
    s.port     = port;
    s.rw       = rw;
    s.addr     = addr;
    s.data     = data;
    s.wait_rsp = wait_rsp;
    steps.push_back(s);
  endfunction

  task automatic build_table();
    i2c_byte_t burst_a;
    i2c_byte_t burst_b;
    burst_a = 8'($random(seed));
    burst_b = 8'($random(seed));
    // Same-cycle writes where port 0 holds the first grant after reset
    add_step("pair_wr_p0", 0, 1'b0, `I2C_SLAVE_ADDR, 8'h3C, 1'b0);
    add_step("pair_wr_p1", 1, 1'b0, `I2C_SLAVE_ADDR, 8'hC3, 1'b1);
    add_step("pair_rd", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b1);
    add_step("wr_p0", 0, 1'b0, `I2C_SLAVE_ADDR, 8'h5A, 1'b1);
    add_step("rd_p0", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b1);
    // Wrong address stores nothing
    add_step("wr_bad_addr", 0, 1'b0, 7'h15, 8'hFF, 1'b1);
    add_step("rd_bad_addr", 1, 1'b1, 7'h15, 8'h00, 1'b1);
    add_step("rd_after_bad", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b1);
    add_step("wr_p0_shared", 0, 1'b0, `I2C_SLAVE_ADDR, 8'h96, 1'b1);
    add_step("rd_p1_shared", 1, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b1);
    // Burst longer than the queue forces a credit stall
    add_step("burst_wr_a", 0, 1'b0, `I2C_SLAVE_ADDR, burst_a, 1'b0);
    add_step("burst_rd_a", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b0);
    add_step("burst_wr_b", 0, 1'b0, `I2C_SLAVE_ADDR, burst_b, 1'b0);
    add_step("burst_rd_b", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b0);
    add_step("burst_wr_bad", 0, 1'b0, 7'h7F, 8'h00, 1'b0);
    add_step("burst_rd_end", 0, 1'b1, `I2C_SLAVE_ADDR, 8'h00, 1'b1);
  endtask

  //////////////////////////////
  // Driver and checks
  //////////////////////////////

  // One clock to the next falling edge, then collect credits and responses
  task automatic advance_cycle();
    string    name;
    i2c_rsp_t want;
    @(negedge clk);
    cmd_valid = '0;
    for (int p = 0; p < N; p++) begin
      if (cmd_credit[p]) begin
        credits[p]++;
        returned[p]++;
        assert (credits[p] <= DEPTH) else begin
          other_errors++;
          $display("Port %0d returned a credit with no queue slot in use", p);
        end
      end
      if (rsp_valid[p]) begin
        assert (pend_rsp[p].size() != 0) else begin
          other_errors++;
          $display("Port %0d sent a response with no command outstanding", p);
        end
        if (pend_rsp[p].size() != 0) begin
          name = pend_name[p].pop_front();
          want = pend_rsp[p].pop_front();
          checks++;
          assert (rsp[p] == want) else begin
            errors++;
            $display("CHECK FAILED %s: expected nack=%0b data=%02h, actual nack=%0b data=%02h",
                     name, want.nack, want.data, rsp[p].nack, rsp[p].data);
          end
        end
      end
    end
  endtask

  // No credit or response pulse, and the bus released high
  task automatic check_quiet_outputs(string name);
    checks++;
    assert ((cmd_credit == '0) && (rsp_valid == '0) && bus.scl && bus.sda) else begin
      errors++;
      $display("CHECK FAILED %s: expected credit=0 rsp_valid=0 scl=1 sda=1,", name);
      $display("  actual credit=%b rsp_valid=%b scl=%b sda=%b",
               cmd_credit, rsp_valid, bus.scl, bus.sda);
    end
  endtask

  task automatic issue_step(input step_t s);
    i2c_cmd_t c;
    i2c_rsp_t want;
    c.rw   = s.rw;
    c.addr = s.addr;
    c.data = s.data;
    cmd[s.port]       = c;
    cmd_valid[s.port] = 1'b1;
    credits[s.port]--;
    issued[s.port]++;
    // Reference model of the slave's byte
    if (s.addr != `I2C_SLAVE_ADDR) begin
      want.nack = 1'b1;
      want.data = '0;
    end else if (s.rw) begin
      want.nack = 1'b0;
      want.data = model_byte;
    end else begin
      model_byte = s.data;
      want.nack  = 1'b0;
      want.data  = '0;
    end
    pend_name[s.port].push_back(s.name);
    pend_rsp[s.port].push_back(want);
  endtask

  task automatic drain_responses();
    int left;
    left = 1;
    while (left != 0) begin
      left = 0;
      for (int p = 0; p < N; p++) begin
        left += pend_rsp[p].size();
      end
      if (left != 0) begin
        advance_cycle();
      end
    end
  endtask

  initial begin : stimulus
    int   idx;
    logic hold;
    seed = 32'h8cbd_0e0f;
    build_table();
    reset        = 1'b1;
    cmd_valid    = '0;
    model_byte   = '0;
    stalls       = 0;
    checks       = 0;
    errors       = 0;
    other_errors = 0;
    for (int p = 0; p < N; p++) begin
      cmd[p]      = '0;
      credits[p]  = DEPTH;
      issued[p]   = 0;
      returned[p] = 0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_quiet_outputs("reset_idle");

    idx = 0;
    while (idx < steps.size()) begin
      // Hold the command until the port has a credit
      while (credits[steps[idx].port] == 0) begin
        stalls++;
        advance_cycle();
      end
      issue_step(steps[idx]);
      hold = steps[idx].wait_rsp;
      // A no-wait step may share its cycle with the next one on the other port
      if (!hold && (idx + 1 < steps.size()) && (steps[idx + 1].port != steps[idx].port)
          && (credits[steps[idx + 1].port] > 0)) begin
        idx++;
        issue_step(steps[idx]);
        hold = steps[idx].wait_rsp;
      end
      idx++;
      advance_cycle();
      if (hold) begin
        drain_responses();
      end
    end
    drain_responses();
    repeat (4) advance_cycle();
    check_quiet_outputs("end_idle");

    for (int p = 0; p < N; p++) begin
      assert ((credits[p] == DEPTH) && (returned[p] == issued[p])) else begin
        other_errors++;
        $display("Port %0d ends with %0d credits, %0d returned for %0d commands",
                 p, credits[p], returned[p], issued[p]);
      end
    end
    assert (stalls > 0) else begin
      other_errors++;
      $display("The sender never ran out of credits during the burst");
    end

    $display("Checks: %0d  mismatches: %0d  other errors: %0d  property failures: %0d",
             checks, errors, other_errors, DUT.u_props.fail_count);
    if ((errors == 0) && (other_errors == 0) && (DUT.u_props.fail_count == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog of 25 SCL periods per table step plus margin
  initial begin : watchdog
    int limit;
    cycle_count = 0;
    @(posedge clk);
    limit = steps.size() * 25 * 2 * `I2C_HALF_PERIOD + 200;
    while (cycle_count < limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the test table did not complete", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- test/i2c_subsystem_props.sv
`include "i2c_cfg.svh"

module i2c_subsystem_props (
  input logic                        clk,
  input logic                        reset,
  input logic [`I2C_NUM_MASTERS-1:0] bus_gnt,
  input i2c_pkg::i2c_line_t          bus,
  input i2c_pkg::master_state_t      m0_state,
  input i2c_pkg::master_state_t      m1_state
);
  timeunit 1ns;
  timeprecision 100ps;
  import i2c_pkg::*;

  int unsigned   fail_count = 0;
  master_state_t owner_state;

  // State of the master that holds the bus
  always_comb begin
    owner_state = mst_idle;
    if (bus_gnt[0]) begin
      owner_state = m0_state;
    end else if (bus_gnt[1]) begin
      owner_state = m1_state;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(bus_gnt))
    else begin
      fail_count++;
      $error("More than one bus grant is high");
    end

  // SDA edges with SCL high belong to start and stop only
  a_sda_stable: assert property (@(posedge clk) disable iff (reset)
      ($changed(bus.sda) && bus.scl && $past(bus.scl))
      |-> (owner_state inside {mst_start, mst_stop}))
    else begin
      fail_count++;
      $error("SDA changed while SCL was high outside start and stop");
    end

  a_idle_high: assert property (@(posedge clk) disable iff (reset)
      (bus_gnt == '0) |-> (bus.scl && bus.sda))
    else begin
      fail_count++;
      $error("Bus line low while no grant is held");
    end

endmodule

bind i2c_subsystem i2c_subsystem_props u_props (
  .clk      (clk),
  .reset    (reset),
  .bus_gnt  (bus_gnt),
  .bus      (bus),
  .m0_state (g_port[0].u_master.state),
  .m1_state (g_port[1].u_master.state)
);

//--- hdl/i2c_subsystem.sv
`include "i2c_cfg.svh"

module i2c_subsystem (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`I2C_NUM_MASTERS-1:0] cmd_valid,
  input  i2c_pkg::i2c_cmd_t           cmd [`I2C_NUM_MASTERS],
  output logic [`I2C_NUM_MASTERS-1:0] cmd_credit,
  output logic [`I2C_NUM_MASTERS-1:0] rsp_valid,
  output i2c_pkg::i2c_rsp_t           rsp [`I2C_NUM_MASTERS],
  output i2c_pkg::i2c_line_t          bus
);
  import i2c_pkg::*;

  localparam int N = `I2C_NUM_MASTERS;

  logic [N-1:0] head_valid;
  i2c_cmd_t     head [N];
  logic [N-1:0] pop;
  logic [N-1:0] bus_req;
  logic [N-1:0] bus_gnt;
  i2c_line_t    drive [N];
  logic         slave_sda;

  // One queue and master per port
  for (genvar i = 0; i < N; i++) begin : g_port
    i2c_cmd_queue u_queue (
      .clk        (clk),
      .reset      (reset),
      .push       (cmd_valid[i]),
      .push_cmd   (cmd[i]),
      .pop        (pop[i]),
      .head_valid (head_valid[i]),
      .head       (head[i]),
      .credit     (cmd_credit[i])
    );

    i2c_master u_master (
      .clk        (clk),
      .reset      (reset),
      .head_valid (head_valid[i]),
      .head       (head[i]),
      .pop        (pop[i]),
      .bus_req    (bus_req[i]),
      .bus_gnt    (bus_gnt[i]),
      .bus_in     (bus),
      .drive      (drive[i]),
      .rsp_valid  (rsp_valid[i]),
      .rsp        (rsp[i])
    );
  end

  i2c_bus_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .bus_req      (bus_req),
    .bus_gnt      (bus_gnt),
    .master_drive (drive),
    .slave_sda    (slave_sda),
    .bus          (bus)
  );

  i2c_reg_slave u_slave (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .sda_drive (slave_sda)
  );

endmodule

//--- hdl/i2c_reg_slave.sv
`include "i2c_cfg.svh"

module i2c_reg_slave (
  input  logic               clk,
  input  logic               reset,
  input  i2c_pkg::i2c_line_t bus,
  output logic               sda_drive
);
  import i2c_pkg::*;

  slave_state_t state;
  i2c_line_t    prev;
  logic [3:0]   cnt;
  i2c_byte_t    shreg;
  i2c_byte_t    stored;
  logic         rw_q;
  logic         scl_rise;
  logic         scl_fall;
  logic         start_det;
  logic         stop_det;
  logic         addr_hit;

  //////////////////////////////
  // Bus event detection
  //////////////////////////////

  assign scl_rise  = bus.scl && !prev.scl;
  assign scl_fall  = !bus.scl && prev.scl;
  // SDA edges count only with SCL high on both samples
  assign start_det = prev.scl && bus.scl && prev.sda && !bus.sda;
  assign stop_det  = prev.scl && bus.scl && !prev.sda && bus.sda;
  assign addr_hit  = (shreg[7:1] == `I2C_SLAVE_ADDR);

  // Sample on rising SCL
  always_ff @(posedge clk) begin
    if (scl_rise) begin
      shreg <= {shreg[6:0], bus.sda};
    end
  end

  //////////////////////////////
  // Slave FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      prev      <= '1;
      state     <= slv_idle;
      cnt       <= 4'd0;
      rw_q      <= 1'b0;
      stored    <= '0;
      sda_drive <= 1'b1;
    end else begin
      prev <= bus;
      if (start_det) begin
        state     <= slv_addr;
        cnt       <= 4'd0;
        sda_drive <= 1'b1;
      end else if (stop_det) begin
        state     <= slv_idle;
        sda_drive <= 1'b1;
      end else if (scl_rise) begin
        if ((state == slv_addr) || (state == slv_data)) begin
          cnt <= cnt + 1'b1;
        end
      end else if (scl_fall) begin
        // Drive changes only after SCL has gone low
        case (state)
          slv_addr: begin
            if (cnt == 4'd8) begin
              cnt  <= 4'd0;
              rw_q <= shreg[0];
              if (addr_hit) begin
                state     <= slv_ack;
                sda_drive <= 1'b0;
              end else begin
                state <= slv_idle;
              end
            end
          end
          slv_ack: begin
            state     <= slv_data;
            sda_drive <= rw_q ? stored[7] : 1'b1;
          end
          slv_data: begin
            if (cnt == 4'd8) begin
              state <= slv_data_ack;
              if (rw_q) begin
                sda_drive <= 1'b1;
              end else begin
                stored    <= shreg;
                sda_drive <= 1'b0;
              end
            end else if (rw_q) begin
              sda_drive <= stored[3'd7 - cnt[2:0]];
            end
          end
          slv_data_ack: begin
            state     <= slv_idle;
            sda_drive <= 1'b1;
          end
          default: sda_drive <= 1'b1;
        endcase
      end
    end
  end

endmodule

//--- hdl/i2c_bus_arbiter.sv
`include "i2c_cfg.svh"

module i2c_bus_arbiter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`I2C_NUM_MASTERS-1:0] bus_req,
  output logic [`I2C_NUM_MASTERS-1:0] bus_gnt,
  input  i2c_pkg::i2c_line_t          master_drive [`I2C_NUM_MASTERS],
  input  logic                        slave_sda,
  output i2c_pkg::i2c_line_t          bus
);
  import i2c_pkg::*;

  localparam int N  = `I2C_NUM_MASTERS;
  localparam int PW = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]  owner;
  logic [PW-1:0] ptr;
  logic [PW-1:0] pick;
  logic          pick_valid;

  assign bus_gnt = owner;

  // First requester at or after the pointer
  always_comb begin
    logic [PW-1:0] idx;
    pick       = '0;
    pick_valid = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = PW'((int'(ptr) + i) % N);
      if (!pick_valid && bus_req[idx]) begin
        pick       = idx;
        pick_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= '0;
      ptr   <= '0;
    end else if (owner == '0) begin
      if (pick_valid) begin
        owner <= N'(1) << pick;
        ptr   <= (pick == PW'(N - 1)) ? '0 : pick + 1'b1;
      end
    end else if ((owner & bus_req) == '0) begin
      owner <= '0;
    end
  end

  // Open-drain wired-AND, non-owners count as released
  always_comb begin
    bus.scl = 1'b1;
    bus.sda = slave_sda;
    for (int i = 0; i < N; i++) begin
      if (owner[i]) begin
        bus.scl = bus.scl & master_drive[i].scl;
        bus.sda = bus.sda & master_drive[i].sda;
      end
    end
  end

endmodule

//--- hdl/i2c_master.sv
`include "i2c_cfg.svh"

module i2c_master (
  input  logic               clk,
  input  logic               reset,
  input  logic               head_valid,
  input  i2c_pkg::i2c_cmd_t  head,
  output logic               pop,
  output logic               bus_req,
  input  logic               bus_gnt,
  input  i2c_pkg::i2c_line_t bus_in,
  output i2c_pkg::i2c_line_t drive,
  output logic               rsp_valid,
  output i2c_pkg::i2c_rsp_t  rsp
);
  import i2c_pkg::*;

  localparam int HW = $clog2(`I2C_HALF_PERIOD + 1);

  master_state_t state;
  logic [HW-1:0] hcnt;
  logic [1:0]    phase;
  logic [2:0]    cnt;
  logic          tick;
  logic          slot_end;
  logic          nack;
  i2c_cmd_t      cmd_q;
  i2c_byte_t     rd_byte;

  // Launch only once the previous request has been dropped
  assign pop = (state == mst_idle) && !bus_req && head_valid;

  assign tick = bus_gnt && (state != mst_idle) && (hcnt == HW'(`I2C_HALF_PERIOD - 1));

  // Stop has a third half period for the SDA rise with SCL high
  assign slot_end = tick && (phase != 2'd0) && !((state == mst_stop) && (phase == 2'd1));

  //////////////////////////////
  // SCL half-period timing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      hcnt <= '0;
    end else if (pop || tick) begin
      hcnt <= '0;
    end else if (bus_gnt && (state != mst_idle)) begin
      hcnt <= hcnt + 1'b1;
    end
  end

  //////////////////////////////
  // Transaction FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= mst_idle;
      phase     <= 2'd0;
      cnt       <= 3'd0;
      bus_req   <= 1'b0;
      nack      <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      if (pop) begin
        state   <= mst_start;
        phase   <= 2'd0;
        bus_req <= 1'b1;
        nack    <= 1'b0;
      end else if (state == mst_idle) begin
        // One idle cycle after stop, then release the bus
        bus_req <= 1'b0;
      end else if (slot_end) begin
        phase <= 2'd0;
        case (state)
          mst_start: begin
            state <= mst_addr;
            cnt   <= 3'd6;
          end
          mst_addr: begin
            if (cnt == 3'd0) begin
              state <= mst_rw;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          mst_rw: state <= mst_ack;
          mst_ack: begin
            // Address NACK skips the data phase
            if (bus_in.sda) begin
              nack  <= 1'b1;
              state <= mst_stop;
            end else begin
              state <= mst_data;
              cnt   <= 3'd7;
            end
          end
          mst_data: begin
            if (cnt == 3'd0) begin
              state <= mst_data_ack;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          mst_data_ack: state <= mst_stop;
          mst_stop: begin
            state     <= mst_idle;
            rsp_valid <= 1'b1;
          end
          default: state <= mst_idle;
        endcase
      end else if (tick) begin
        phase <= phase + 2'd1;
      end
    end
  end

  // Command copy, read capture at the end of SCL high, response
  always_ff @(posedge clk) begin
    if (pop) begin
      cmd_q <= head;
    end
    if (slot_end && (state == mst_data)) begin
      rd_byte[cnt] <= bus_in.sda;
    end
    if (slot_end && (state == mst_stop)) begin
      rsp.nack <= nack;
      // Only a successful read returns a byte
      rsp.data <= (nack || !cmd_q.rw) ? '0 : rd_byte;
    end
  end

  //////////////////////////////
  // Line drive
  //////////////////////////////

  always_comb begin
    drive.scl = phase[0];
    drive.sda = 1'b1;
    case (state)
      mst_idle: drive.scl = 1'b1;
      mst_start: begin
        // SCL held high, SDA falls in the second half
        drive.scl = 1'b1;
        drive.sda = (phase == 2'd0);
      end
      mst_addr: drive.sda = cmd_q.addr[cnt];
      mst_rw:   drive.sda = cmd_q.rw;
      // Released on a read so the slave can drive
      mst_data: drive.sda = cmd_q.rw | cmd_q.data[cnt];
      mst_stop: begin
        drive.scl = (phase != 2'd0);
        drive.sda = (phase == 2'd2);
      end
      default: drive.sda = 1'b1;
    endcase
  end

endmodule

//--- hdl/i2c_cmd_queue.sv
`include "i2c_cfg.svh"

module i2c_cmd_queue (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  i2c_pkg::i2c_cmd_t push_cmd,
  input  logic              pop,
  output logic              head_valid,
  output i2c_pkg::i2c_cmd_t head,
  output logic              credit
);
  import i2c_pkg::*;

  localparam int DEPTH = `I2C_QUEUE_DEPTH;
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  i2c_cmd_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign do_pop     = pop && head_valid;

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // One credit back per freed slot
      credit <= do_pop;
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/i2c_pkg.sv
package i2c_pkg;

  typedef logic [6:0] i2c_addr_t;
  typedef logic [7:0] i2c_byte_t;

  // One queued command, rw = 1 is a read
  typedef struct packed {
    logic      rw;
    i2c_addr_t addr;
    i2c_byte_t data;
  } i2c_cmd_t;

  // Completion of one command
  typedef struct packed {
    logic      nack;
    i2c_byte_t data;
  } i2c_rsp_t;

  // Drive level of one agent, or the resolved bus
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_line_t;

  typedef enum logic [2:0] {
    mst_idle,
    mst_start,
    mst_addr,
    mst_rw,
    mst_ack,
    mst_data,
    mst_data_ack,
    mst_stop
  } master_state_t;

  typedef enum logic [2:0] {
    slv_idle,
    slv_addr,
    slv_ack,
    slv_data,
    slv_data_ack
  } slave_state_t;

endpackage

//--- hdl/i2c_cfg.svh
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

//////////////////////////////
// Subsystem parameters
//////////////////////////////

// Command slots per master, equal to the sender's starting credit
`define I2C_QUEUE_DEPTH 4

// clk cycles in one SCL half period
`define I2C_HALF_PERIOD 4

// Address of the register slave
`define I2C_SLAVE_ADDR 7'h2A

// Peer masters sharing the bus
`define I2C_NUM_MASTERS 2

`endif
